// ==== source/plb_pkg.sv ====
package plb_pkg;

  localparam int plb_bytes  = 4;
  localparam int plb_data_w = 8 * plb_bytes;
  localparam int plb_addr_w = 32;

  // FIFO sizing
  localparam int fifo_depth    = 8;
  localparam int fifo_nf_slack = 3;

  // One local bus write
  typedef struct packed {
    logic [plb_addr_w-1:0] addr;
    logic [plb_data_w-1:0] data;
    logic [plb_bytes-1:0]  be;
  } plb_wr_t;

endpackage

// ==== source/axi_pkg.sv ====
package axi_pkg;

  import plb_pkg::*;

  localparam int axi_id_w    = 2;
  localparam int axi_len_w   = 8;
  localparam int axi_size_w  = 3;
  localparam int axi_burst_w = 2;
  localparam int axi_resp_w  = 2;

  localparam logic [axi_burst_w-1:0] axi_burst_incr  = 2'b01;
  localparam logic [axi_resp_w-1:0]  axi_resp_okay   = 2'b00;
  localparam logic [axi_resp_w-1:0]  axi_resp_slverr = 2'b10;

  // Write address beat
  typedef struct packed {
    logic [axi_id_w-1:0]    id;
    logic [plb_addr_w-1:0]  addr;
    logic [axi_len_w-1:0]   len;
    logic [axi_size_w-1:0]  size;
    logic [axi_burst_w-1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    logic [plb_data_w-1:0] data;
    logic [plb_bytes-1:0]  strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_resp_w-1:0] resp;
  } axi_b_t;

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
  import plb_pkg::*;
#(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [width-1:0] wr_data,
  input  logic             wr_vld,
  output logic             wr_rdy,
  output logic             nf,
  output logic [width-1:0] rd_data,
  output logic             rd_vld,
  input  logic             rd_rdy
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam int cnt_w = $clog2(fifo_depth + 1);

  logic [width-1:0] mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_rdy  = (count != cnt_w'(fifo_depth));
  assign rd_vld  = (count != '0);
  assign push    = wr_vld && wr_rdy;
  assign pop     = rd_vld && rd_rdy;
  assign rd_data = mem[rd_ptr];

  // Includes the write landing this cycle
  // so the writes still in the upstream pipeline always fit
  assign nf = (count + cnt_w'(push)) > cnt_w'(fifo_depth - fifo_nf_slack);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// ==== source/burst_addr_gen.sv ====
`timescale 1ns/1ps

module burst_addr_gen
  import axi_pkg::*;
  import plb_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  axi_aw_t               aw,
  input  logic                  beat,
  output logic [plb_addr_w-1:0] beat_addr,
  output logic                  last_beat,
  output logic                  burst_done
);

  logic                  start_q;
  logic [plb_addr_w-1:0] base_addr;
  logic [axi_len_w-1:0]  len_q;
  logic [axi_size_w-1:0] size_q;
  logic [axi_len_w-1:0]  cntr;
  logic                  fin_q;
  logic [plb_addr_w-1:0] prev_addr;
  logic [plb_addr_w-1:0] step;

  assign step = plb_addr_w'(1) << size_q;

  // First beat of a burst takes the captured start address
  assign beat_addr = start_q ? base_addr : prev_addr + step;

  assign last_beat  = beat && (cntr == len_q);
  assign burst_done = fin_q || last_beat;

  always_ff @(posedge clk) begin
    if (start) begin
      base_addr <= aw.addr;
      len_q     <= aw.len;
      size_q    <= aw.size;
    end
    if (beat) begin
      prev_addr <= beat_addr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  // Beat counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cntr <= '0;
    end else if (start) begin
      cntr <= '0;
    end else if (beat) begin
      cntr <= cntr + 1'b1;
    end
  end

  // Idle counts as finished so the first AW can go
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fin_q <= 1'b1;
    end else if (start) begin
      fin_q <= 1'b0;
    end else if (last_beat) begin
      fin_q <= 1'b1;
    end
  end

endmodule

// ==== source/wr_burst_engine.sv ====
`timescale 1ns/1ps

module wr_burst_engine
  import axi_pkg::*;
  import plb_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  axi_aw_t aw,
  input  logic    aw_vld,
  output logic    aw_rdy,
  input  axi_w_t  w,
  input  logic    w_vld,
  output logic    w_rdy,
  output plb_wr_t plb_req,
  output logic    plb_req_vld,
  input  logic    plb_nf,
  output axi_b_t  b,
  output logic    b_vld,
  input  logic    b_nf
);

  logic                   room;
  logic                   aw_pop;
  logic                   w_pop;
  logic                   burst_done;
  logic                   last_beat;
  logic [plb_addr_w-1:0]  beat_addr;
  logic [axi_burst_w-1:0] burst_q;
  logic [axi_id_w-1:0]    id_q;
  logic [axi_burst_w-1:0] s2_burst;
  logic [axi_id_w-1:0]    s2_id;
  axi_w_t                 s1_w;
  logic                   s1_vld;
  axi_w_t                 s2_w;
  logic [plb_addr_w-1:0]  s2_addr;
  logic                   s2_vld;
  logic                   s2_final;
  logic                   s2_mismatch;
  logic                   err_q;
  logic [axi_resp_w-1:0]  s2_resp;

  assign room   = !plb_nf && !b_nf;
  assign aw_rdy = room && w_vld && burst_done;
  assign w_rdy  = room && (aw_vld || !burst_done);
  assign aw_pop = aw_vld && aw_rdy;
  assign w_pop  = w_vld && w_rdy;

  burst_addr_gen u_addr_gen (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (aw_pop),
    .aw         (aw),
    .beat       (s1_vld),
    .beat_addr  (beat_addr),
    .last_beat  (last_beat),
    .burst_done (burst_done)
  );

  // Burst attributes trail by a cycle so stage 2 still sees the old burst
  // when the next AW is popped right after a final beat
  always_ff @(posedge clk) begin
    if (aw_pop) begin
      burst_q <= aw.burst;
      id_q    <= aw.id;
    end
    s2_burst <= burst_q;
    s2_id    <= id_q;
    s1_w     <= w;
    s2_w     <= s1_w;
    s2_addr  <= beat_addr;
    plb_req  <= '{addr: s2_addr, data: s2_w.data, be: s2_w.strb};
    b        <= '{id: s2_id, resp: s2_resp};
  end

  assign s2_mismatch = s2_vld && (s2_w.last != s2_final);
  assign s2_resp = (err_q || s2_mismatch || (s2_burst != axi_burst_incr)) ?
                   axi_resp_slverr : axi_resp_okay;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_vld      <= 1'b0;
      s2_vld      <= 1'b0;
      s2_final    <= 1'b0;
      plb_req_vld <= 1'b0;
      b_vld       <= 1'b0;
    end else begin
      s1_vld      <= w_pop;
      s2_vld      <= s1_vld;
      s2_final    <= last_beat;
      plb_req_vld <= s2_vld;
      b_vld       <= s2_final;
    end
  end

  // Sticky wlast error across the beats of one burst
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else if (s2_vld) begin
      err_q <= s2_final ? 1'b0 : (err_q || s2_mismatch);
    end
  end

endmodule

// ==== source/axi_wr_bridge.sv ====
`timescale 1ns/1ps

module axi_wr_bridge
  import axi_pkg::*;
  import plb_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [axi_id_w-1:0]    awid,
  input  logic [plb_addr_w-1:0]  awaddr,
  input  logic [axi_len_w-1:0]   awlen,
  input  logic [axi_size_w-1:0]  awsize,
  input  logic [axi_burst_w-1:0] awburst,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [plb_data_w-1:0]  wdata,
  input  logic [plb_bytes-1:0]   wstrb,
  input  logic                   wlast,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [axi_id_w-1:0]    bid,
  output logic [axi_resp_w-1:0]  bresp,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [plb_addr_w-1:0]  plb_addr,
  output logic [plb_data_w-1:0]  plb_data,
  output logic [plb_bytes-1:0]   plb_be,
  output logic                   plb_vld,
  input  logic                   plb_rdy
);

  axi_aw_t aw_in;
  axi_aw_t aw_out;
  logic    aw_out_vld;
  logic    aw_out_rdy;
  axi_w_t  w_in;
  axi_w_t  w_out;
  logic    w_out_vld;
  logic    w_out_rdy;
  plb_wr_t plb_in;
  logic    plb_in_vld;
  logic    plb_nf;
  plb_wr_t plb_out;
  axi_b_t  b_in;
  logic    b_in_vld;
  logic    b_nf;
  axi_b_t  b_out;

  assign aw_in = '{id: awid, addr: awaddr, len: awlen, size: awsize, burst: awburst};
  assign w_in  = '{data: wdata, strb: wstrb, last: wlast};

  assign plb_addr = plb_out.addr;
  assign plb_data = plb_out.data;
  assign plb_be   = plb_out.be;
  assign bid      = b_out.id;
  assign bresp    = b_out.resp;

  // Input side
  sync_fifo #(.width($bits(axi_aw_t))) u_aw_fifo (
    .clk (clk), .arst_n (arst_n),
    .wr_data (aw_in), .wr_vld (awvalid), .wr_rdy (awready), .nf (),
    .rd_data (aw_out), .rd_vld (aw_out_vld), .rd_rdy (aw_out_rdy)
  );

  sync_fifo #(.width($bits(axi_w_t))) u_w_fifo (
    .clk (clk), .arst_n (arst_n),
    .wr_data (w_in), .wr_vld (wvalid), .wr_rdy (wready), .nf (),
    .rd_data (w_out), .rd_vld (w_out_vld), .rd_rdy (w_out_rdy)
  );

  wr_burst_engine u_engine (
    .clk (clk), .arst_n (arst_n),
    .aw (aw_out), .aw_vld (aw_out_vld), .aw_rdy (aw_out_rdy),
    .w (w_out), .w_vld (w_out_vld), .w_rdy (w_out_rdy),
    .plb_req (plb_in), .plb_req_vld (plb_in_vld), .plb_nf (plb_nf),
    .b (b_in), .b_vld (b_in_vld), .b_nf (b_nf)
  );

  // Output FIFOs never fill because the engine stops on nf
  sync_fifo #(.width($bits(plb_wr_t))) u_plb_fifo (
    .clk (clk), .arst_n (arst_n),
    .wr_data (plb_in), .wr_vld (plb_in_vld), .wr_rdy (), .nf (plb_nf),
    .rd_data (plb_out), .rd_vld (plb_vld), .rd_rdy (plb_rdy)
  );

  sync_fifo #(.width($bits(axi_b_t))) u_b_fifo (
    .clk (clk), .arst_n (arst_n),
    .wr_data (b_in), .wr_vld (b_in_vld), .wr_rdy (), .nf (b_nf),
    .rd_data (b_out), .rd_vld (bvalid), .rd_rdy (bready)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== verification/axi_wr_bridge_checker.sv ====
`timescale 1ns/1ps

module axi_wr_bridge_checker
  import axi_pkg::*;
  import plb_pkg::*;
(
  input logic                  clk,
  input logic                  arst_n,
  input logic                  plb_vld,
  input logic                  plb_rdy,
  input logic [plb_addr_w-1:0] plb_addr,
  input logic [plb_data_w-1:0] plb_data,
  input logic [plb_bytes-1:0]  plb_be,
  input logic                  bvalid,
  input logic                  bready,
  input logic [axi_id_w-1:0]   bid,
  input logic [axi_resp_w-1:0] bresp
);

  int fail_count = 0;

  // Stalled PLB write keeps its payload
  plb_hold: assert property (@(posedge clk) disable iff (!arst_n)
    plb_vld && !plb_rdy |=> plb_vld && $stable({plb_addr, plb_data, plb_be}))
    else begin
      fail_count++;
      $error("PLB write changed or dropped while stalled");
    end

  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable({bid, bresp}))
    else begin
      fail_count++;
      $error("B response changed or dropped while stalled");
    end

  reset_quiet: assert property (@(posedge clk) !arst_n |-> !plb_vld && !bvalid)
    else begin
      fail_count++;
      $error("Output valid raised during reset");
    end

  bresp_legal: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid |-> (bresp == axi_resp_okay || bresp == axi_resp_slverr))
    else begin
      fail_count++;
      $error("Response code is neither OKAY nor SLVERR");
    end

endmodule

// ==== verification/axi_wr_bridge_tb.sv ====
`timescale 1ns/1ps

module axi_wr_bridge_tb
  import axi_pkg::*;
  import plb_pkg::*;
();

  // Worst case of 8 beats for every burst
  localparam int n_bursts        = 29;
  localparam int watchdog_cycles = n_bursts * 8 * 40 + 1000;

  logic                   clk;
  logic                   arst_n;
  logic [axi_id_w-1:0]    awid;
  logic [plb_addr_w-1:0]  awaddr;
  logic [axi_len_w-1:0]   awlen;
  logic [axi_size_w-1:0]  awsize;
  logic [axi_burst_w-1:0] awburst;
  logic                   awvalid;
  logic                   awready;
  logic [plb_data_w-1:0]  wdata;
  logic [plb_bytes-1:0]   wstrb;
  logic                   wlast;
  logic                   wvalid;
  logic                   wready;
  logic [axi_id_w-1:0]    bid;
  logic [axi_resp_w-1:0]  bresp;
  logic                   bvalid;
  logic                   bready;
  logic [plb_addr_w-1:0]  plb_addr;
  logic [plb_data_w-1:0]  plb_data;
  logic [plb_bytes-1:0]   plb_be;
  logic                   plb_vld;
  logic                   plb_rdy;

  logic [31:0] rng_state = 32'd35;
  logic        random_ready = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  axi_aw_t     aw_q[$];
  axi_w_t      w_q[$];
  plb_wr_t     exp_plb[$];
  axi_b_t      exp_b[$];

  tb_clock_gen #(.period_ns(20), .reset_cycles(5)) u_clk_gen (.clk (clk), .arst_n (arst_n));

  axi_wr_bridge uut (.*);

  bind axi_wr_bridge axi_wr_bridge_checker u_checker (
    .clk (clk), .arst_n (arst_n), .plb_vld (plb_vld), .plb_rdy (plb_rdy),
    .plb_addr (plb_addr), .plb_data (plb_data), .plb_be (plb_be),
    .bvalid (bvalid), .bready (bready), .bid (bid), .bresp (bresp)
  );

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {rng_state[15:0], rng_state[31:16]};
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Wlast mode 0 is correct, 1 marks the beat before the final one, 2 never marks
  task automatic add_burst(input logic [axi_burst_w-1:0] burst, input int wlast_mode);
    axi_aw_t aw;
    axi_w_t  w;
    plb_wr_t p;
    axi_b_t  b;
    int      beats;
    beats = int'(rand_next() % 32'd8) + 1;
    if (wlast_mode == 1 && beats < 2) begin
      beats = 2;
    end
    aw.id    = axi_id_w'(rand_next());
    aw.addr  = rand_next();
    aw.len   = axi_len_w'(beats - 1);
    aw.size  = axi_size_w'(rand_next() % 32'd3);
    aw.burst = burst;
    aw_q.push_back(aw);
    for (int k = 0; k < beats; k++) begin
      w.data = rand_next();
      w.strb = plb_bytes'(rand_next());
      w.last = (wlast_mode == 0) ? (k == beats - 1) : (wlast_mode == 1) ? (k == beats - 2) : 1'b0;
      w_q.push_back(w);
      p.addr = aw.addr + (plb_addr_w'(k) << aw.size);
      p.data = w.data;
      p.be   = w.strb;
      exp_plb.push_back(p);
    end
    b.id   = aw.id;
    b.resp = (burst == axi_burst_incr && wlast_mode == 0) ? axi_resp_okay : axi_resp_slverr;
    exp_b.push_back(b);
  endtask

  task automatic drive_aw();
    axi_aw_t aw;
    logic    fire;
    while (aw_q.size() > 0) begin
      aw = aw_q.pop_front();
      awid    = aw.id;
      awaddr  = aw.addr;
      awlen   = aw.len;
      awsize  = aw.size;
      awburst = aw.burst;
      awvalid = 1'b1;
      fire    = 1'b0;
      while (!fire) begin
        fire = awready;
        @(negedge clk);
      end
    end
    awvalid = 1'b0;
  endtask

  task automatic drive_w();
    axi_w_t w;
    logic   fire;
    while (w_q.size() > 0) begin
      w = w_q.pop_front();
      wdata  = w.data;
      wstrb  = w.strb;
      wlast  = w.last;
      wvalid = 1'b1;
      fire   = 1'b0;
      while (!fire) begin
        fire = wready;
        @(negedge clk);
      end
    end
    wvalid = 1'b0;
  endtask

  task automatic run_test(input string name);
    int errors_before;
    errors_before = errors;
    fork
      drive_aw();
      drive_w();
    join
    while (exp_plb.size() > 0 || exp_b.size() > 0) begin
      @(negedge clk);
    end
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
  endtask

  // Output ready runs and scoreboard
  initial begin : output_side
    int          plb_run;
    int          b_run;
    logic [31:0] r;
    plb_wr_t     exp_w;
    axi_b_t      exp_r;
    plb_run = 0;
    b_run   = 0;
    plb_rdy = 1'b0;
    bready  = 1'b0;
    forever begin
      @(negedge clk);
      if (!random_ready) begin
        plb_rdy = 1'b1;
        bready  = 1'b1;
      end else begin
        if (plb_run == 0) begin
          r = rand_next();
          plb_rdy = r[0];
          plb_run = int'(r[4:1]) + 1;
        end
        if (b_run == 0) begin
          r = rand_next();
          bready = r[0];
          b_run  = int'(r[4:1]) + 1;
        end
        plb_run--;
        b_run--;
      end
      if (arst_n && plb_vld && plb_rdy) begin
        assert (exp_plb.size() > 0) else begin
          $display("Unexpected PLB write at %0t with none outstanding", $time);
          errors++;
        end
        if (exp_plb.size() > 0) begin
          exp_w = exp_plb.pop_front();
          expect_equal("plb_addr", exp_w.addr, plb_addr);
          expect_equal("plb_data", exp_w.data, plb_data);
          expect_equal("plb_be", 32'(exp_w.be), 32'(plb_be));
        end
      end
      if (arst_n && bvalid && bready) begin
        assert (exp_b.size() > 0) else begin
          $display("Unexpected write response at %0t with none outstanding", $time);
          errors++;
        end
        if (exp_b.size() > 0) begin
          exp_r = exp_b.pop_front();
          expect_equal("bid", 32'(exp_r.id), 32'(bid));
          expect_equal("bresp", 32'(exp_r.resp), 32'(bresp));
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    wait (arst_n === 1'b1);
    @(negedge clk);
    expect_equal("plb_vld", 32'(0), 32'(plb_vld));
    expect_equal("bvalid", 32'(0), 32'(bvalid));
    expect_equal("awready", 32'(1), 32'(awready));
    expect_equal("wready", 32'(1), 32'(wready));
    tests_run++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("Test 1 reset_state: %0d errors", errors);
    for (int i = 0; i < 6; i++) begin
      add_burst(axi_burst_incr, 0);
    end
    run_test("incr_bursts");
    add_burst(2'b00, 0);
    add_burst(2'b10, 0);
    add_burst(2'b11, 0);
    run_test("non_incr_bursts");
    add_burst(axi_burst_incr, 1);
    add_burst(axi_burst_incr, 0);
    add_burst(axi_burst_incr, 2);
    add_burst(axi_burst_incr, 0);
    run_test("wlast_errors");
    for (int i = 0; i < 16; i++) begin
      r = rand_next();
      add_burst((r[1:0] == 2'b00) ? 2'b00 : axi_burst_incr,
                (r[4:2] == 3'd0) ? 2 : (r[4:2] == 3'd1) ? 1 : 0);
    end
    // Ready pattern starts away from the edge the output side samples on
    @(posedge clk);
    random_ready = 1'b1;
    @(negedge clk);
    run_test("backpressure");
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, uut.u_checker.fail_count);
    if (errors == 0 && uut.u_checker.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== axi_wr_bridge.f ====
source/plb_pkg.sv
source/axi_pkg.sv
source/sync_fifo.sv
source/burst_addr_gen.sv
source/wr_burst_engine.sv
source/axi_wr_bridge.sv
verification/tb_clock_gen.sv
verification/axi_wr_bridge_checker.sv
verification/axi_wr_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axi_wr_bridge_tb
FILELIST  ?= axi_wr_bridge.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
